// File: Makefile
SIM = obj_dir/sim_csr_unit

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_csr_unit \
		-f build.f -Mdir obj_dir -o sim_csr_unit

run: compile
	./$(SIM) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: build.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_apb_port.sv
rtl/csr_except_regs.sv
rtl/csr_timer.sv
rtl/csr_unit.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_csr_assert.sv
testbench/tb_csr_unit.sv

// File: rtl/csr_apb_port.sv
module csr_apb_port
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  csr_num_t  paddr,
    input  csr_word_t pwdata,
    input  csr_word_t wmask,
    output csr_word_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      wr_en,
    output csr_num_t  wr_num,
    output csr_word_t wr_data,
    output csr_num_t  rd_num,
    input  csr_word_t exc_rd_data,
    input  csr_word_t tmr_rd_data,
    input  logic      exc_rd_hit,
    input  logic      tmr_rd_hit
);

    logic      setup_q;     // previous cycle was a setup phase
    logic      access;
    logic      rd_any_hit;
    csr_word_t rd_merged;

    always_ff @(posedge clk)
    begin
        if (!rstn)
            setup_q <= 1'b0;
        else
            setup_q <= psel & ~penable;
    end

    assign access = psel & penable & setup_q;

    // blocks return zero for numbers they do not own
    assign rd_num     = paddr;
    assign rd_any_hit = exc_rd_hit | tmr_rd_hit;
    assign rd_merged  = exc_rd_data | tmr_rd_data;

    // no wait states
    assign pready  = psel & penable;
    assign pslverr = psel & penable & ~(setup_q & rd_any_hit);
    assign prdata  = (access && rd_any_hit) ? rd_merged : '0;

    // masked bits keep the current value, csrxchg style
    assign wr_en   = access & pwrite & rd_any_hit;
    assign wr_num  = paddr;
    assign wr_data = (rd_merged & ~wmask) | (pwdata & wmask);

endmodule

// File: rtl/csr_except_regs.sv
`include "csr_macros.svh"

module csr_except_regs
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       wr_en,
    input  csr_num_t   wr_num,
    input  csr_num_t   rd_num,
    input  csr_word_t  wr_data,
    output csr_word_t  rd_data,
    output logic       rd_hit,
    input  logic       excp_valid,
    input  logic       ertn_valid,
    input  ecode_t     excp_ecode,
    input  csr_word_t  excp_pc,
    input  int_lines_t hw_int,
    input  logic       timer_irq,
    output logic       ti_clr_req,
    output logic       redirect_valid,
    output csr_word_t  redirect_pc,
    output csr_word_t  crmd,
    output logic       int_pending
);

    csr_word_t                  crmd_q;     // only [8:0] ever change
    plv_t                       prmd_pplv;
    logic                       prmd_pie;
    logic [`ECFG_LIE_W-1:0]     ecfg_lie;
    logic [1:0]                 estat_sw;
    ecode_t                     estat_ecode;
    logic [`ECFG_LIE_W-1:0]     estat_is;
    csr_word_t                  era_q;
    logic [31:`EENTRY_ALIGN]    eentry_q;
    csr_word_t                  save_q [4];
    plv_t                       cur_plv;
    csr_word_t                  eentry_pc;
    logic                       redirect_q;

    assign cur_plv   = crmd_q[1:0];
    assign eentry_pc = {eentry_q, {`EENTRY_ALIGN{1'b0}}};

    // pending sources, ipi and bit 10 unused
    always_comb
    begin
        estat_is            = '0;
        estat_is[1:0]       = estat_sw;
        estat_is[9:2]       = hw_int;
        estat_is[`ESTAT_TI] = timer_irq;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q      <= `CRMD_RESET;
            prmd_pplv   <= '0;
            prmd_pie    <= 1'b0;
            ecfg_lie    <= '0;
            estat_sw    <= '0;
            estat_ecode <= '0;
            era_q       <= '0;
            eentry_q    <= '0;
            save_q      <= '{default: '0};
            redirect_q  <= 1'b0;
        end
        else
        begin
            redirect_q <= excp_valid | ertn_valid;
            if (wr_en)
            begin
                case (wr_num)
                    `CSR_CRMD:
                    begin
                        crmd_q[2:0] <= wr_data[2:0];
                        crmd_q[8:5] <= wr_data[8:5];
                        // da/pg only move to a legal pair
                        if (wr_data[`CRMD_DA+1] ^ wr_data[`CRMD_DA])
                            crmd_q[`CRMD_DA+1:`CRMD_DA] <= wr_data[`CRMD_DA+1:`CRMD_DA];
                    end
                    `CSR_PRMD:
                    begin
                        prmd_pplv <= wr_data[1:0];
                        prmd_pie  <= wr_data[2];
                    end
                    `CSR_ECFG:   ecfg_lie <= wr_data[`ECFG_LIE_W-1:0] & 13'h0bff;
                    `CSR_ESTAT:  estat_sw <= wr_data[1:0];    // software irqs only
                    `CSR_ERA:    era_q    <= wr_data;
                    `CSR_EENTRY: eentry_q <= wr_data[31:`EENTRY_ALIGN];
                    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                        save_q[wr_num[1:0]] <= wr_data;
                    default: ;
                endcase
            end
            // pipeline events override a same-cycle apb write
            if (excp_valid)
            begin
                prmd_pplv          <= cur_plv;
                prmd_pie           <= crmd_q[`CRMD_IE];
                crmd_q[`CRMD_IE:0] <= '0;
                era_q              <= excp_pc;
                estat_ecode        <= excp_ecode;
            end
            else if (ertn_valid)
            begin
                crmd_q[1:0]      <= prmd_pplv;
                crmd_q[`CRMD_IE] <= prmd_pie;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (excp_valid)
            redirect_pc <= eentry_pc;
        else if (ertn_valid)
            redirect_pc <= era_q;
    end

    always_comb
    begin
        rd_data = '0;
        rd_hit  = 1'b1;
        case (rd_num)
            `CSR_CRMD:   rd_data = crmd_q;
            `CSR_PRMD:   rd_data = {29'b0, prmd_pie, prmd_pplv};
            `CSR_ECFG:   rd_data = {{(32-`ECFG_LIE_W){1'b0}}, ecfg_lie};
            `CSR_ESTAT:  rd_data = {10'b0, estat_ecode, 3'b0, estat_is};
            `CSR_ERA:    rd_data = era_q;
            `CSR_EENTRY: rd_data = eentry_pc;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_data = save_q[rd_num[1:0]];
            default:     rd_hit = 1'b0;
        endcase
    end

    // TICLR itself lives in the timer
    assign ti_clr_req = wr_en && (wr_num == `CSR_TICLR) && wr_data[0];

    assign redirect_valid = redirect_q;
    assign crmd           = crmd_q;
    assign int_pending    = crmd_q[`CRMD_IE] & (|(estat_is & ecfg_lie));

endmodule

// File: rtl/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// csr numbers
`define CSR_CRMD    16'h0000
`define CSR_PRMD    16'h0001
`define CSR_ECFG    16'h0004
`define CSR_ESTAT   16'h0005
`define CSR_ERA     16'h0006
`define CSR_EENTRY  16'h000C
`define CSR_SAVE0   16'h0030
`define CSR_SAVE1   16'h0031
`define CSR_SAVE2   16'h0032
`define CSR_SAVE3   16'h0033
`define CSR_TID     16'h0040
`define CSR_TCFG    16'h0041
`define CSR_TVAL    16'h0042
`define CSR_TICLR   16'h0044

// field positions
`define CRMD_IE       2
`define CRMD_DA       3    // pg sits one above
`define ESTAT_TI      11
`define ECFG_LIE_W    13
`define EENTRY_ALIGN  6

// da=1, plv0, ie off
`define CRMD_RESET  32'h0000_0008

`endif

// File: rtl/csr_pkg.sv
package csr_pkg;

    // csr number as carried on paddr
    typedef logic [15:0] csr_num_t;

    typedef logic [31:0] csr_word_t;

    // exception code, ESTAT[21:16]
    typedef logic [5:0]  ecode_t;

    typedef logic [1:0]  plv_t;    // privilege level

    // hardware interrupt lines, ESTAT[9:2]
    typedef logic [7:0]  int_lines_t;

endpackage

// File: rtl/csr_timer.sv
`include "csr_macros.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      wr_en,
    input  csr_num_t  wr_num,
    input  csr_num_t  rd_num,
    input  csr_word_t wr_data,
    output csr_word_t rd_data,
    output logic      rd_hit,
    input  logic      ti_clr_req,
    output logic      timer_irq
);

    csr_word_t tid_q;
    csr_word_t tcfg_q;
    csr_word_t tval_q;
    logic      tcfg_load;     // tval loads one edge after the tcfg write
    logic      ti_q;
    logic      tmr_en;
    logic      tmr_periodic;
    csr_word_t reload_val;

    assign tmr_en       = tcfg_q[0];
    assign tmr_periodic = tcfg_q[1];
    assign reload_val   = {tcfg_q[31:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tid_q     <= '0;
            tcfg_q    <= '0;
            tval_q    <= '0;
            tcfg_load <= 1'b0;
            ti_q      <= 1'b0;
        end
        else
        begin
            tcfg_load <= 1'b0;
            if (wr_en && wr_num == `CSR_TID)
                tid_q <= wr_data;
            if (wr_en && wr_num == `CSR_TCFG)
            begin
                tcfg_q    <= wr_data;
                tcfg_load <= wr_data[0];
            end

            if (tmr_en)
            begin
                if (tcfg_load)
                    tval_q <= reload_val;
                else if (tval_q == '0)
                    tval_q <= tmr_periodic ? reload_val : '1;   // one-shot wraps and holds
                else if (tval_q != '1)
                    tval_q <= tval_q - 32'd1;
            end

            if (ti_clr_req)
                ti_q <= 1'b0;
            else if (tmr_en && !tcfg_load && tval_q == '0)
                ti_q <= 1'b1;
        end
    end

    always_comb
    begin
        rd_data = '0;
        rd_hit  = 1'b1;
        case (rd_num)
            `CSR_TID:   rd_data = tid_q;
            `CSR_TCFG:  rd_data = tcfg_q;
            `CSR_TVAL:  rd_data = tval_q;    // read only
            `CSR_TICLR: rd_data = '0;
            default:    rd_hit = 1'b0;
        endcase
    end

    assign timer_irq = ti_q;

endmodule

// File: rtl/csr_unit.sv
module csr_unit
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  csr_num_t   paddr,
    input  csr_word_t  pwdata,
    input  csr_word_t  wmask,
    output csr_word_t  prdata,
    output logic       pready,
    output logic       pslverr,
    input  logic       excp_valid,
    input  ecode_t     excp_ecode,
    input  csr_word_t  excp_pc,
    input  logic       ertn_valid,
    input  int_lines_t hw_int,
    output logic       redirect_valid,
    output csr_word_t  redirect_pc,
    output csr_word_t  crmd,
    output logic       int_pending
);

    logic      wr_en;
    csr_num_t  wr_num;
    csr_word_t wr_data;
    csr_num_t  rd_num;
    csr_word_t exc_rd_data;
    csr_word_t tmr_rd_data;
    logic      exc_rd_hit;
    logic      tmr_rd_hit;
    logic      timer_irq;
    logic      ti_clr_req;

    csr_apb_port apb_port_inst (
        .clk         (clk),
        .rstn        (rstn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .wmask       (wmask),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .wr_en       (wr_en),
        .wr_num      (wr_num),
        .wr_data     (wr_data),
        .rd_num      (rd_num),
        .exc_rd_data (exc_rd_data),
        .tmr_rd_data (tmr_rd_data),
        .exc_rd_hit  (exc_rd_hit),
        .tmr_rd_hit  (tmr_rd_hit)
    );

    csr_except_regs except_regs_inst (
        .clk            (clk),
        .rstn           (rstn),
        .wr_en          (wr_en),
        .wr_num         (wr_num),
        .rd_num         (rd_num),
        .wr_data        (wr_data),
        .rd_data        (exc_rd_data),
        .rd_hit         (exc_rd_hit),
        .excp_valid     (excp_valid),
        .ertn_valid     (ertn_valid),
        .excp_ecode     (excp_ecode),
        .excp_pc        (excp_pc),
        .hw_int         (hw_int),
        .timer_irq      (timer_irq),
        .ti_clr_req     (ti_clr_req),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .crmd           (crmd),
        .int_pending    (int_pending)
    );

    csr_timer timer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .wr_en      (wr_en),
        .wr_num     (wr_num),
        .rd_num     (rd_num),
        .wr_data    (wr_data),
        .rd_data    (tmr_rd_data),
        .rd_hit     (tmr_rd_hit),
        .ti_clr_req (ti_clr_req),
        .timer_irq  (timer_irq)
    );

endmodule

// File: testbench/tb_checker.sv
`include "csr_macros.svh"

module tb_checker
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      psel,
    input  logic      penable,
    input  csr_num_t  paddr,
    input  csr_word_t prdata,
    input  logic      pready,
    input  logic      pslverr,
    input  logic      redirect_valid,
    input  csr_word_t redirect_pc,
    input  csr_word_t crmd,
    input  logic      int_pending,
    input  logic      chk_apb,
    input  logic      chk_rdata,
    input  logic      chk_redir,
    input  logic      chk_level,
    input  csr_word_t exp_data,
    input  logic      exp_err,
    input  int        row_idx,
    output int        checks,
    output int        errors
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors_before;

    task automatic compare(input string what, input csr_word_t got, input csr_word_t want);
        if (got !== want)
        begin
            errors = errors + 1;
            $display("ERROR at %0d ns: row %0d, %s is 0x%08h, expected 0x%08h",
                     $time, row_idx, what, got, want);
        end
    endtask

    task automatic finish_row(input string kind);
        checks = checks + 1;
        if (errors == errors_before)
            $display("row %0d %s ok", row_idx, kind);
        else
            $display("row %0d %s mismatch", row_idx, kind);
    endtask

    initial
    begin
        checks = 0;
        errors = 0;
    end

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk)
    begin
        errors_before = errors;
        if (chk_apb)
        begin
            compare("pready", {31'b0, pready}, 32'd1);
            compare("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
            if (chk_rdata)
            begin
                compare("prdata", prdata, exp_data);
                if (paddr == `CSR_CRMD)
                    compare("crmd", crmd, exp_data);    // output port mirrors the register
                finish_row("apb read");
            end
            else
                finish_row("apb write");
        end
        if (chk_redir)
        begin
            compare("redirect_valid", {31'b0, redirect_valid}, 32'd1);
            compare("redirect_pc", redirect_pc, exp_data);
            finish_row("redirect");
        end
        if (chk_level)
        begin
            compare("int_pending", {31'b0, int_pending}, exp_data);
            finish_row("interrupt");
        end
    end

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    // held low for 8 rising edges, released just after the last one
    initial
    begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

// File: testbench/tb_csr_assert.sv
`include "csr_macros.svh"

module tb_csr_assert
    import csr_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input logic      psel,
    input logic      penable,
    input logic      pslverr,
    input logic      redirect_valid,
    input csr_word_t crmd
);
    timeunit 1ns;
    timeprecision 1ps;

    // error only in an access phase that follows a setup
    err_in_access: assert property (@(posedge clk) disable iff (!rstn)
        pslverr |-> (psel && penable && $past(psel && !penable)))
        else $error("pslverr high outside an access cycle");

    reset_state: assert property (@(posedge clk)
        $rose(rstn) |-> (!redirect_valid && crmd == `CRMD_RESET))
        else $error("redirect_valid or crmd wrong right after reset");

    redirect_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid held for two cycles");

endmodule

// redirect_valid is not visible inside the apb port, so attach at the top
bind csr_unit tb_csr_assert csr_assert_inst (
    .clk            (clk),
    .rstn           (rstn),
    .psel           (psel),
    .penable        (penable),
    .pslverr        (pslverr),
    .redirect_valid (redirect_valid),
    .crmd           (crmd)
);

// File: testbench/tb_csr_unit.sv
`include "csr_macros.svh"

module tb_csr_unit
    import csr_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [2:0] OP_WR    = 3'd0;
    localparam logic [2:0] OP_RD    = 3'd1;
    localparam logic [2:0] OP_EXC   = 3'd2;
    localparam logic [2:0] OP_ERTN  = 3'd3;
    localparam logic [2:0] OP_WAIT  = 3'd4;
    localparam logic [2:0] OP_HWINT = 3'd5;
    localparam logic [2:0] OP_IRQ   = 3'd6;
    localparam csr_word_t  ALL      = 32'hffff_ffff;

    typedef struct packed {
        logic [2:0] op;
        csr_num_t   num;
        csr_word_t  data;    // pc for an exception, count for a wait, level for hw_int
        csr_word_t  mask;    // ecode for an exception
        csr_word_t  want;
        logic       err;
    } row_t;

    logic       clk;
    logic       rstn;
    logic       psel;
    logic       penable;
    logic       pwrite;
    csr_num_t   paddr;
    csr_word_t  pwdata;
    csr_word_t  wmask;
    csr_word_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       excp_valid;
    ecode_t     excp_ecode;
    csr_word_t  excp_pc;
    logic       ertn_valid;
    int_lines_t hw_int;
    logic       redirect_valid;
    csr_word_t  redirect_pc;
    csr_word_t  crmd;
    logic       int_pending;

    logic       chk_apb;
    logic       chk_rdata;
    logic       chk_redir;
    logic       chk_level;
    csr_word_t  exp_data;
    logic       exp_err;
    int         row_idx;
    int         checks;
    int         errors;
    int         n_checks;
    int         max_cycles;
    int         cycles = 0;
    logic [31:0] rnd;
    row_t       rows[$];

    tb_clock clock_inst (
        .clk  (clk),
        .rstn (rstn)
    );

    csr_unit csr_unit_inst (
        .clk            (clk),
        .rstn           (rstn),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .wmask          (wmask),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .excp_valid     (excp_valid),
        .excp_ecode     (excp_ecode),
        .excp_pc        (excp_pc),
        .ertn_valid     (ertn_valid),
        .hw_int         (hw_int),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .crmd           (crmd),
        .int_pending    (int_pending)
    );

    tb_checker checker_inst (
        .clk            (clk),
        .psel           (psel),
        .penable        (penable),
        .paddr          (paddr),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .crmd           (crmd),
        .int_pending    (int_pending),
        .chk_apb        (chk_apb),
        .chk_rdata      (chk_rdata),
        .chk_redir      (chk_redir),
        .chk_level      (chk_level),
        .exp_data       (exp_data),
        .exp_err        (exp_err),
        .row_idx        (row_idx),
        .checks         (checks),
        .errors         (errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input logic [2:0] op, input csr_num_t num, input csr_word_t data,
                           input csr_word_t mask, input csr_word_t want, input logic err);
        row_t r;
        r.op   = op;
        r.num  = num;
        r.data = data;
        r.mask = mask;
        r.want = want;
        r.err  = err;
        rows.push_back(r);
        if (op != OP_HWINT)
            n_checks = n_checks + 1;
    endtask

    task automatic build_table();
        csr_word_t save_val [4];
        csr_word_t save1_new;
        rnd = 32'd94254;
        add_row(OP_RD, `CSR_CRMD, '0, '0, `CRMD_RESET, 1'b0);
        add_row(OP_RD, `CSR_PRMD, '0, '0, '0, 1'b0);
        add_row(OP_RD, `CSR_ESTAT, '0, '0, '0, 1'b0);
        add_row(OP_RD, `CSR_ERA, '0, '0, '0, 1'b0);
        add_row(OP_RD, `CSR_SAVE0, '0, '0, '0, 1'b0);
        add_row(OP_RD, `CSR_TVAL, '0, '0, '0, 1'b0);
        for (int k = 0; k < 4; k++)
        begin
            rnd = xorshift32(rnd);
            save_val[k] = rnd;
            add_row(OP_WR, csr_num_t'(`CSR_SAVE0 + k), rnd, ALL, '0, 1'b0);
        end
        for (int k = 0; k < 4; k++)
            add_row(OP_RD, csr_num_t'(`CSR_SAVE0 + k), '0, '0, save_val[k], 1'b0);
        add_row(OP_WR, `CSR_ERA, 32'h1c00_0100, ALL, '0, 1'b0);
        add_row(OP_RD, `CSR_ERA, '0, '0, 32'h1c00_0100, 1'b0);
        // csrxchg on the low half
        save1_new = {save_val[1][31:16], 16'ha5a5};
        add_row(OP_WR, `CSR_SAVE1, 32'ha5a5_a5a5, 32'h0000_ffff, '0, 1'b0);
        add_row(OP_RD, `CSR_SAVE1, '0, '0, save1_new, 1'b0);
        add_row(OP_WR, 16'h0099, 32'h1, ALL, '0, 1'b1);
        add_row(OP_RD, 16'h0099, '0, '0, '0, 1'b1);
        add_row(OP_WR, `CSR_TVAL, 32'h1234, ALL, '0, 1'b0);
        add_row(OP_RD, `CSR_TVAL, '0, '0, '0, 1'b0);
        // da=pg=1 is illegal, so those two stay at da=1 pg=0
        add_row(OP_WR, `CSR_CRMD, 32'h1f, ALL, '0, 1'b0);
        add_row(OP_RD, `CSR_CRMD, '0, '0, 32'h0f, 1'b0);
        add_row(OP_WR, `CSR_EENTRY, 32'h1c00_807f, ALL, '0, 1'b0);
        add_row(OP_RD, `CSR_EENTRY, '0, '0, 32'h1c00_8040, 1'b0);
        add_row(OP_EXC, '0, 32'h1c00_0234, 32'h0000_000b, 32'h1c00_8040, 1'b0);
        add_row(OP_RD, `CSR_PRMD, '0, '0, 32'h7, 1'b0);
        add_row(OP_RD, `CSR_CRMD, '0, '0, 32'h8, 1'b0);
        add_row(OP_RD, `CSR_ERA, '0, '0, 32'h1c00_0234, 1'b0);
        add_row(OP_RD, `CSR_ESTAT, '0, '0, 32'h000b_0000, 1'b0);
        add_row(OP_ERTN, '0, '0, '0, 32'h1c00_0234, 1'b0);
        add_row(OP_RD, `CSR_CRMD, '0, '0, 32'h0f, 1'b0);
        // one-shot timer, initial count 20
        add_row(OP_WR, `CSR_ECFG, 32'h800, ALL, '0, 1'b0);
        add_row(OP_WR, `CSR_TCFG, 32'h15, ALL, '0, 1'b0);
        add_row(OP_WAIT, '0, 32'd20, '0, 32'h1, 1'b0);
        add_row(OP_RD, `CSR_ESTAT, '0, '0, 32'h000b_0800, 1'b0);
        add_row(OP_WR, `CSR_TICLR, 32'h1, ALL, '0, 1'b0);
        add_row(OP_RD, `CSR_ESTAT, '0, '0, 32'h000b_0000, 1'b0);
        add_row(OP_IRQ, '0, '0, '0, 32'h0, 1'b0);
        add_row(OP_WR, `CSR_ECFG, 32'h804, ALL, '0, 1'b0);
        add_row(OP_HWINT, '0, 32'h01, '0, '0, 1'b0);
        add_row(OP_RD, `CSR_ESTAT, '0, '0, 32'h000b_0004, 1'b0);
        add_row(OP_IRQ, '0, '0, '0, 32'h1, 1'b0);
        add_row(OP_WR, `CSR_CRMD, 32'h0, 32'h4, '0, 1'b0);    // clear ie only
        add_row(OP_IRQ, '0, '0, '0, 32'h0, 1'b0);
        add_row(OP_HWINT, '0, 32'h00, '0, '0, 1'b0);
    endtask

    function automatic int table_cycles();
        int total;
        total = 0;
        foreach (rows[i])
        begin
            if (rows[i].op == OP_WAIT)
                total = total + int'(rows[i].data) + 3;
            else if (rows[i].op == OP_HWINT || rows[i].op == OP_IRQ)
                total = total + 1;
            else
                total = total + 2;
        end
        return total;
    endfunction

    task automatic apb_access(input logic wr, input row_t r);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = r.num;
        pwdata  = r.data;
        wmask   = r.mask;
        @(posedge clk);
        #1;
        penable   = 1'b1;
        exp_data  = r.want;
        exp_err   = r.err;
        chk_rdata = ~wr;
        chk_apb   = 1'b1;
        @(posedge clk);
        #1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        chk_apb   = 1'b0;
        chk_rdata = 1'b0;
    endtask

    task automatic pipe_event(input row_t r);
        excp_valid = (r.op == OP_EXC);
        ertn_valid = (r.op == OP_ERTN);
        excp_pc    = r.data;
        excp_ecode = r.mask[5:0];
        @(posedge clk);
        #1;
        excp_valid = 1'b0;
        ertn_valid = 1'b0;
        exp_data   = r.want;
        chk_redir  = 1'b1;    // redirect shows in this cycle
        @(posedge clk);
        #1;
        chk_redir = 1'b0;
    endtask

    task automatic check_irq(input logic want);
        exp_data  = {31'b0, want};
        chk_level = 1'b1;
        @(posedge clk);
        #1;
        chk_level = 1'b0;
    endtask

    task automatic wait_irq(input row_t r);
        int n;
        n = 0;
        while (int_pending !== 1'b1 && n < int'(r.data) + 2)
        begin
            @(posedge clk);
            #1;
            n = n + 1;
        end
        check_irq(r.want[0]);
    endtask

    task automatic run_row(input int i);
        row_t r;
        r = rows[i];
        row_idx = i;
        case (r.op)
            OP_WR:   apb_access(1'b1, r);
            OP_RD:   apb_access(1'b0, r);
            OP_EXC,
            OP_ERTN: pipe_event(r);
            OP_WAIT: wait_irq(r);
            OP_HWINT:
            begin
                hw_int = r.data[7:0];
                @(posedge clk);
                #1;
            end
            default: check_irq(r.want[0]);
        endcase
    endtask

    initial
    begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        wmask      = '0;
        excp_valid = 1'b0;
        excp_ecode = '0;
        excp_pc    = '0;
        ertn_valid = 1'b0;
        hw_int     = '0;
        chk_apb    = 1'b0;
        chk_rdata  = 1'b0;
        chk_redir  = 1'b0;
        chk_level  = 1'b0;
        exp_data   = '0;
        exp_err    = 1'b0;
        row_idx    = 0;
        n_checks   = 0;
        build_table();
        max_cycles = 2 * (8 + table_cycles()) + 50;
        wait (rstn === 1'b1);
        @(posedge clk);
        #1;
        foreach (rows[i])
            run_row(i);
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks == n_checks)
            $display("STATUS: PASS");
        else
        begin
            if (checks != n_checks)
                $display("only %0d of %0d checks were made", checks, n_checks);
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule
